/* Makefile */
TOP := tb_julia_render

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

obj_dir/$(TOP): tb.f hdl/*.sv bench/*.sv
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o $(TOP)

# the run passes only when the pass line shows up in the output
sim: obj_dir/$(TOP)
	@out="$$(./obj_dir/$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir

/* bench/tb_julia_render.sv */
`timescale 1ns/100ps

module tb_julia_render import julia_pkg::*; import mem_bus_pkg::*; ();

	localparam int clk_period = 20;
	localparam int drive_delay = 2;
	localparam int frame_timeout = 20000;

	logic clk = 1'b0;
	logic n_rst;
	logic start;
	logic signed [coord_w-1:0] c_re;
	logic signed [coord_w-1:0] c_im;
	logic [addr_w-1:0] frame_base;
	logic wait_request;
	logic busy;
	logic frame_done;
	logic write_enable;
	logic [addr_w-1:0] write_address;
	logic [data_w-1:0] write_data;

	// memory responder state
	logic random_wait;
	int seed = 32'h76fb_d853;

	// bus monitor results
	logic [data_w-1:0] mem [logic [addr_w-1:0]];
	int write_count = 0;
	int dup_count = 0;
	int stall_count = 0;
	int frames_done = 0;

	// expected counts per pixel in raster order
	logic [data_w-1:0] model [num_pixels];

	int error_count;
	int check_count;

	always #(clk_period / 2) clk = ~clk;

	julia_render_top dut_i (
		.clk           (clk),
		.n_rst         (n_rst),
		.start         (start),
		.c_re          (c_re),
		.c_im          (c_im),
		.frame_base    (frame_base),
		.wait_request  (wait_request),
		.busy          (busy),
		.frame_done    (frame_done),
		.write_enable  (write_enable),
		.write_address (write_address),
		.write_data    (write_data)
	);

	// wait_request is either always low or a coin flip per cycle
	initial begin
		logic [31:0] r;
		wait_request = 1'b0;
		forever begin
			@(posedge clk);
			#drive_delay;
			if (random_wait) begin
				r = $random(seed);
				wait_request = r[0];
			end else begin
				wait_request = 1'b0;
			end
		end
	end

	// mid-cycle sampling of the bus
	always @(negedge clk) begin
		if (n_rst) begin
			if (write_enable && wait_request) begin
				stall_count++;
			end
			if (write_enable && !wait_request) begin
				if (mem.exists(write_address)) begin
					dup_count++;
				end
				mem[write_address] = write_data;
				write_count++;
			end
			if (frame_done) begin
				frames_done++;
			end
		end
	end

	task automatic compare_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
		end
	endtask

	// z^2+c in 12-bit fraction fixed point with the escape test before each step
	function automatic int escape_count(input int px, input int py, input int cr, input int ci);
		int re;
		int im;
		int re_sq;
		int im_sq;
		int cross_term;
		int count;
		logic finished;
		re = -(3 << frac_bits) / 2 + px * ((3 << frac_bits) / 8);
		im = -(3 << frac_bits) / 2 + py * ((3 << frac_bits) / 8);
		count = 0;
		finished = 1'b0;
		while (!finished) begin
			re_sq = int'((longint'(re) * longint'(re)) >>> frac_bits);
			im_sq = int'((longint'(im) * longint'(im)) >>> frac_bits);
			cross_term = int'((longint'(re) * longint'(im)) >>> frac_bits);
			if ((re_sq + im_sq) > (4 << frac_bits) || count == max_iter) begin
				finished = 1'b1;
			end else begin
				re = re_sq - im_sq + cr;
				im = 2 * cross_term + ci;
				count++;
			end
		end
		return count;
	endfunction

	task automatic build_model(input int cr, input int ci);
		for (int y = 0; y < frame_h; y++) begin
			for (int x = 0; x < frame_w; x++) begin
				model[y * frame_w + x] = escape_count(x, y, cr, ci);
			end
		end
	endtask

	task automatic pulse_start();
		@(posedge clk);
		#drive_delay;
		start = 1'b1;
		@(posedge clk);
		#drive_delay;
		start = 1'b0;
	endtask

	task automatic wait_frame_done(input int frames_before);
		int cycles;
		cycles = 0;
		while (frames_done == frames_before && cycles < frame_timeout) begin
			@(posedge clk);
			cycles++;
		end
		if (frames_done == frames_before) begin
			error_count++;
			$display("timeout: frame_done did not arrive within %0d cycles", frame_timeout);
		end
	endtask

	task automatic verify_frame(input logic [31:0] base);
		logic [31:0] addr;
		for (int i = 0; i < num_pixels; i++) begin
			addr = base + 32'(i);
			if (!mem.exists(addr)) begin
				error_count++;
				$display("no write arrived for address 0x%08h", addr);
			end else begin
				compare_value($sformatf("write_data[0x%08h]", addr), model[i], mem[addr]);
			end
		end
		compare_value("duplicate writes", 0, dup_count);
	endtask

	task automatic render_frame(input int cr, input int ci, input logic [31:0] base);
		int frames_before;
		int writes_before;
		@(posedge clk);
		#drive_delay;
		c_re = cr;
		c_im = ci;
		frame_base = base;
		build_model(cr, ci);
		frames_before = frames_done;
		writes_before = write_count;
		pulse_start();
		wait_frame_done(frames_before);
		#drive_delay;
		compare_value("busy", 0, 32'(busy));
		compare_value("write count", num_pixels, write_count - writes_before);
		verify_frame(base);
	endtask

	task automatic idle_after_reset();
		repeat (10) @(posedge clk);
		#drive_delay;
		compare_value("write_enable", 0, 32'(write_enable));
		compare_value("busy", 0, 32'(busy));
		compare_value("frame_done", 0, 32'(frame_done));
		compare_value("writes before start", 0, write_count);
		compare_value("frame_done pulses", 0, frames_done);
	endtask

	// c = (-0.75, 0.125)
	task automatic frame_without_stalls();
		random_wait = 1'b0;
		render_frame(-(3 << frac_bits) / 4, (1 << frac_bits) / 8, 32'h0000_1000);
	endtask

	task automatic frame_with_random_stalls();
		int stalls_before;
		random_wait = 1'b1;
		stalls_before = stall_count;
		render_frame(-(3 << frac_bits) / 4, (1 << frac_bits) / 8, 32'h0000_2000);
		if (stall_count == stalls_before) begin
			error_count++;
			$display("the bus never stalled a write during the random wait frame");
		end
	endtask

	// c about (-0.4, 0.6)
	task automatic frame_with_new_constant();
		render_frame(-1638, 2458, 32'h0000_3000);
	endtask

	task automatic start_while_busy();
		int frames_before;
		int writes_before;
		int cycles;
		@(posedge clk);
		#drive_delay;
		c_re = -(3 << frac_bits) / 4;
		c_im = (1 << frac_bits) / 8;
		frame_base = 32'h0000_4000;
		build_model(-(3 << frac_bits) / 4, (1 << frac_bits) / 8);
		frames_before = frames_done;
		writes_before = write_count;
		pulse_start();
		cycles = 0;
		while (write_count - writes_before < 8 && cycles < frame_timeout) begin
			@(posedge clk);
			cycles++;
		end
		if (write_count - writes_before < 8) begin
			error_count++;
			$display("timeout: the frame wrote fewer than 8 pixels after start");
		end
		#drive_delay;
		compare_value("busy", 1, 32'(busy));
		// this start lands in the middle of the frame
		pulse_start();
		wait_frame_done(frames_before);
		// room for a second frame to show up if start was taken
		repeat (300) @(posedge clk);
		#drive_delay;
		compare_value("busy", 0, 32'(busy));
		compare_value("frame_done pulses", 1, frames_done - frames_before);
		compare_value("write count", num_pixels, write_count - writes_before);
		verify_frame(32'h0000_4000);
	endtask

	initial begin
		int assert_fails;
		error_count = 0;
		check_count = 0;
		random_wait = 1'b0;
		n_rst = 1'b0;
		start = 1'b0;
		c_re = '0;
		c_im = '0;
		frame_base = '0;
		repeat (4) @(posedge clk);
		#drive_delay;
		n_rst = 1'b1;

		idle_after_reset();
		frame_without_stalls();
		frame_with_random_stalls();
		frame_with_new_constant();
		start_while_busy();

		assert_fails = dut_i.writer_i.writer_assertions_i.fail_count;
		error_count += assert_fails;
		$display("checks %0d, errors %0d, assertion failures %0d", check_count,
			error_count, assert_fails);
		if (error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* bench/writer_assertions.sv */
`timescale 1ns/100ps

module writer_assertions import julia_pkg::*; import mem_bus_pkg::*; (
	input logic                   clk,
	input logic                   n_rst,
	input logic                   found,
	input logic                   take,
	input logic [num_engines-1:0] mask,
	input logic                   wait_request,
	input logic                   write_enable,
	input logic                   write_accepted,
	input logic [num_engines-1:0] free,
	input logic [addr_w-1:0]      write_address,
	input logic [data_w-1:0]      write_data
);

	int fail_count = 0;

	// a stalled request keeps its address, data and enable
	bus_held: assert property (@(posedge clk) disable iff (!n_rst)
		write_enable && wait_request |=>
			write_enable && $stable(write_address) && $stable(write_data))
	else begin
		fail_count++;
		$error("write request changed while wait_request was high");
	end

	// exactly one engine released per accepted word
	accept_frees_one: assert property (@(posedge clk) disable iff (!n_rst)
		write_accepted |-> $onehot(free))
	else begin
		fail_count++;
		$error("an accepted write did not free exactly one engine");
	end

	// selection only when the search offers a single engine
	take_one_engine: assert property (@(posedge clk) disable iff (!n_rst)
		take |-> found && $onehot(mask))
	else begin
		fail_count++;
		$error("take was raised without exactly one selected engine");
	end

endmodule

bind pixel_writer writer_assertions writer_assertions_i (
	.clk            (clk),
	.n_rst          (n_rst),
	.found          (found),
	.take           (take),
	.mask           (mask),
	.wait_request   (wait_request),
	.write_enable   (write_enable),
	.write_accepted (write_accepted),
	.free           (free),
	.write_address  (write_address),
	.write_data     (write_data)
);

/* hdl/done_search.sv */
`timescale 1ns/100ps

module done_search import julia_pkg::*; import mem_bus_pkg::*; (
	input  logic                   clk,
	input  logic                   n_rst,
	input  logic [num_engines-1:0] done,
	input  logic [addr_w-1:0]      pix_address [num_engines],
	input  pixel_t                 pix_count [num_engines],
	input  logic                   take,
	output logic                   found,
	output logic [addr_w-1:0]      sel_address,
	output logic [data_w-1:0]      sel_data,
	output logic [num_engines-1:0] mask
);

	logic [engine_idx_w-1:0] ptr;
	logic [engine_idx_w-1:0] sel_idx;
	logic [engine_idx_w-1:0] pick_idx;
	logic pick_found;
	// engines already handed to the writer
	logic [num_engines-1:0] held;
	logic [num_engines-1:0] held_next;
	logic [num_engines-1:0] cand;

	// a taken engine stays held until its done drops
	assign held_next = (held | (take ? mask : '0)) & done;
	assign cand = done & ~held_next;

	// first candidate at or after the pointer
	always_comb begin
		int idx;
		pick_found = 1'b0;
		pick_idx = '0;
		for (int k = 0; k < num_engines; k++) begin
			idx = (int'(ptr) + k) % num_engines;
			if (!pick_found && cand[idx]) begin
				pick_found = 1'b1;
				pick_idx = engine_idx_w'(idx);
			end
		end
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			found <= 1'b0;
			mask <= '0;
			sel_idx <= '0;
			ptr <= '0;
			held <= '0;
		end else begin
			found <= pick_found;
			mask <= pick_found ? (num_engines'(1) << pick_idx) : '0;
			sel_idx <= pick_idx;
			held <= held_next;
			// move past the engine just taken
			if (take) begin
				if (sel_idx == engine_idx_w'(num_engines - 1)) begin
					ptr <= '0;
				end else begin
					ptr <= sel_idx + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		sel_address <= pix_address[pick_idx];
		sel_data <= data_w'(pix_count[pick_idx]);
	end

endmodule

/* hdl/julia_engine.sv */
`timescale 1ns/100ps

module julia_engine import julia_pkg::*; import mem_bus_pkg::*; (
	input  logic                      clk,
	input  logic                      n_rst,
	input  logic                      job_valid,
	input  logic [pix_x_w-1:0]        job_x,
	input  logic [pix_y_w-1:0]        job_y,
	input  logic signed [coord_w-1:0] c_re,
	input  logic signed [coord_w-1:0] c_im,
	input  logic [addr_w-1:0]         frame_base,
	input  logic                      free,
	output logic                      job_ready,
	output logic                      done,
	output logic [addr_w-1:0]         pix_address,
	output pixel_t                    pix_count
);

	typedef enum logic [1:0] {
		eng_idle,
		eng_iter,
		eng_done
	} eng_state_t;

	eng_state_t state;

	// current z and the constant for this job
	logic signed [coord_w-1:0] re;
	logic signed [coord_w-1:0] im;
	logic signed [coord_w-1:0] c_re_q;
	logic signed [coord_w-1:0] c_im_q;
	pixel_t count;

	// full width products before rescaling
	logic signed [2*coord_w-1:0] re_sq_full;
	logic signed [2*coord_w-1:0] im_sq_full;
	logic signed [2*coord_w-1:0] cross_full;
	logic signed [coord_w-1:0] re_sq;
	logic signed [coord_w-1:0] im_sq;
	logic signed [coord_w-1:0] cross_term;

	logic escape;
	logic finish;

	assign re_sq_full = re * re;
	assign im_sq_full = im * im;
	assign cross_full = re * im;

	// slice equals an arithmetic shift right by frac_bits
	assign re_sq = re_sq_full[coord_w+frac_bits-1:frac_bits];
	assign im_sq = im_sq_full[coord_w+frac_bits-1:frac_bits];
	assign cross_term = cross_full[coord_w+frac_bits-1:frac_bits];

	assign escape = (re_sq + im_sq) > escape_limit;
	assign finish = escape || (count == pixel_t'(max_iter));

	assign job_ready = (state == eng_idle);
	assign done = (state == eng_done);
	assign pix_count = count;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state <= eng_idle;
		end else begin
			case (state)
				eng_idle: begin
					if (job_valid) begin
						state <= eng_iter;
					end
				end
				eng_iter: begin
					if (finish) begin
						state <= eng_done;
					end
				end
				eng_done: begin
					// result stays up until the writer frees it
					if (free) begin
						state <= eng_idle;
					end
				end
				default: begin
					state <= eng_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == eng_idle && job_valid) begin
			re <= x_min + $signed(coord_w'(job_x)) * step;
			im <= y_min + $signed(coord_w'(job_y)) * step;
			c_re_q <= c_re;
			c_im_q <= c_im;
			count <= '0;
			pix_address <= frame_base + addr_w'(job_y) * frame_w + addr_w'(job_x);
		end else if (state == eng_iter && !finish) begin
			// z <= z^2 + c
			re <= re_sq - im_sq + c_re_q;
			im <= cross_term + cross_term + c_im_q;
			count <= count + 1'b1;
		end
	end

endmodule

/* hdl/julia_pkg.sv */
package julia_pkg;

	// engine pool
	localparam int num_engines = 4;
	localparam int engine_idx_w = $clog2(num_engines);

	// signed fixed point with 12 fraction bits
	localparam int frac_bits = 12;
	// wide enough that no iteration overflows
	localparam int coord_w = 32;

	// iteration cap
	localparam int max_iter = 63;

	// frame geometry
	localparam int frame_w = 8;
	localparam int frame_h = 8;
	localparam int num_pixels = frame_w * frame_h;
	localparam int pix_cnt_w = $clog2(num_pixels + 1);
	localparam int pix_x_w = 3;
	localparam int pix_y_w = 3;

	// pixel (0,0) sits at -1.5 on both axes
	localparam logic signed [coord_w-1:0] x_min = -(3 << (frac_bits - 1));
	localparam logic signed [coord_w-1:0] y_min = -(3 << (frac_bits - 1));
	// 0.375 between neighbours
	localparam logic signed [coord_w-1:0] step = 3 << (frac_bits - 3);

	// escape when |z|^2 exceeds 4.0
	localparam logic signed [coord_w-1:0] escape_limit = 4 << frac_bits;

endpackage

/* hdl/julia_render_top.sv */
`timescale 1ns/100ps

module julia_render_top import julia_pkg::*; import mem_bus_pkg::*; (
	input  logic                      clk,
	input  logic                      n_rst,
	input  logic                      start,
	input  logic signed [coord_w-1:0] c_re,
	input  logic signed [coord_w-1:0] c_im,
	input  logic [addr_w-1:0]         frame_base,
	input  logic                      wait_request,
	output logic                      busy,
	output logic                      frame_done,
	output logic                      write_enable,
	output logic [addr_w-1:0]         write_address,
	output logic [data_w-1:0]         write_data
);

	// job handshake
	logic [num_engines-1:0] job_valid;
	logic [num_engines-1:0] job_ready;
	logic [pix_x_w-1:0] job_x;
	logic [pix_y_w-1:0] job_y;

	// results from the engines
	logic [num_engines-1:0] done;
	logic [addr_w-1:0] pix_address [num_engines];
	pixel_t pix_count [num_engines];

	// search to writer
	logic found;
	logic take;
	logic [addr_w-1:0] sel_address;
	logic [data_w-1:0] sel_data;
	logic [num_engines-1:0] mask;
	logic [num_engines-1:0] free;
	logic write_accepted;

	pixel_dispatch dispatch_i (
		.clk            (clk),
		.n_rst          (n_rst),
		.start          (start),
		.job_ready      (job_ready),
		.write_accepted (write_accepted),
		.job_valid      (job_valid),
		.job_x          (job_x),
		.job_y          (job_y),
		.busy           (busy),
		.frame_done     (frame_done)
	);

	for (genvar i = 0; i < num_engines; i++) begin : g_engine
		julia_engine engine_i (
			.clk         (clk),
			.n_rst       (n_rst),
			.job_valid   (job_valid[i]),
			.job_x       (job_x),
			.job_y       (job_y),
			.c_re        (c_re),
			.c_im        (c_im),
			.frame_base  (frame_base),
			.free        (free[i]),
			.job_ready   (job_ready[i]),
			.done        (done[i]),
			.pix_address (pix_address[i]),
			.pix_count   (pix_count[i])
		);
	end

	done_search search_i (
		.clk         (clk),
		.n_rst       (n_rst),
		.done        (done),
		.pix_address (pix_address),
		.pix_count   (pix_count),
		.take        (take),
		.found       (found),
		.sel_address (sel_address),
		.sel_data    (sel_data),
		.mask        (mask)
	);

	pixel_writer writer_i (
		.clk            (clk),
		.n_rst          (n_rst),
		.found          (found),
		.sel_address    (sel_address),
		.sel_data       (sel_data),
		.mask           (mask),
		.wait_request   (wait_request),
		.take           (take),
		.free           (free),
		.write_address  (write_address),
		.write_data     (write_data),
		.write_enable   (write_enable),
		.write_accepted (write_accepted)
	);

endmodule

/* hdl/mem_bus_pkg.sv */
package mem_bus_pkg;

	// word addressed write bus
	localparam int addr_w = 32;
	localparam int data_w = 32;

	// escape count as stored per pixel
	localparam int pixel_w = 8;

	typedef logic [pixel_w-1:0] pixel_t;

endpackage

/* hdl/pixel_dispatch.sv */
`timescale 1ns/100ps

module pixel_dispatch import julia_pkg::*; (
	input  logic                   clk,
	input  logic                   n_rst,
	input  logic                   start,
	input  logic [num_engines-1:0] job_ready,
	input  logic                   write_accepted,
	output logic [num_engines-1:0] job_valid,
	output logic [pix_x_w-1:0]     job_x,
	output logic [pix_y_w-1:0]     job_y,
	output logic                   busy,
	output logic                   frame_done
);

	logic issuing;
	logic handoff;
	logic last_x;
	logic last_y;
	logic [pix_cnt_w-1:0] written;

	// lowest set bit of ready picks the engine
	assign job_valid = issuing ? (job_ready & (~job_ready + 1'b1)) : '0;
	assign handoff = |job_valid;

	assign last_x = (job_x == pix_x_w'(frame_w - 1));
	assign last_y = (job_y == pix_y_w'(frame_h - 1));

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			busy <= 1'b0;
			issuing <= 1'b0;
			frame_done <= 1'b0;
			job_x <= '0;
			job_y <= '0;
			written <= '0;
		end else begin
			frame_done <= 1'b0;
			if (start && !busy) begin
				busy <= 1'b1;
				issuing <= 1'b1;
				job_x <= '0;
				job_y <= '0;
				written <= '0;
			end else begin
				// raster order, x first
				if (handoff) begin
					if (last_x) begin
						job_x <= '0;
						if (last_y) begin
							issuing <= 1'b0;
						end else begin
							job_y <= job_y + 1'b1;
						end
					end else begin
						job_x <= job_x + 1'b1;
					end
				end
				// frame ends with the last accepted write
				if (write_accepted && busy) begin
					if (written == pix_cnt_w'(num_pixels - 1)) begin
						busy <= 1'b0;
						frame_done <= 1'b1;
						written <= '0;
					end else begin
						written <= written + 1'b1;
					end
				end
			end
		end
	end

endmodule

/* hdl/pixel_writer.sv */
`timescale 1ns/100ps

module pixel_writer import julia_pkg::*; import mem_bus_pkg::*; (
	input  logic                   clk,
	input  logic                   n_rst,
	input  logic                   found,
	input  logic [addr_w-1:0]      sel_address,
	input  logic [data_w-1:0]      sel_data,
	input  logic [num_engines-1:0] mask,
	input  logic                   wait_request,
	output logic                   take,
	output logic [num_engines-1:0] free,
	output logic [addr_w-1:0]      write_address,
	output logic [data_w-1:0]      write_data,
	output logic                   write_enable,
	output logic                   write_accepted
);

	typedef enum logic [1:0] {
		seek,
		request,
		gap
	} wr_state_t;

	wr_state_t state;
	// engine that owns the pixel on the bus
	logic [num_engines-1:0] mask_q;

	assign take = (state == seek) && found;
	assign write_enable = (state == request);
	assign write_accepted = write_enable && !wait_request;
	// release the engine as the bus takes the word
	assign free = write_accepted ? mask_q : '0;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state <= seek;
			mask_q <= '0;
		end else begin
			case (state)
				seek: begin
					if (found) begin
						state <= request;
						mask_q <= mask;
					end
				end
				request: begin
					// hold everything while the bus stalls
					if (!wait_request) begin
						state <= gap;
					end
				end
				gap: begin
					state <= seek;
				end
				default: begin
					state <= seek;
				end
			endcase
		end
	end

	// address and data latched with the selection
	always_ff @(posedge clk) begin
		if (take) begin
			write_address <= sel_address;
			write_data <= sel_data;
		end
	end

endmodule

/* tb.f */
hdl/julia_pkg.sv
hdl/mem_bus_pkg.sv
hdl/pixel_dispatch.sv
hdl/julia_engine.sv
hdl/done_search.sv
hdl/pixel_writer.sv
hdl/julia_render_top.sv
bench/writer_assertions.sv
bench/tb_julia_render.sv
